//--- neo_save_pkg.sv
package neo_save_pkg;

	// ====================
	// SD block transfer
	// ====================

	// Host SD block address width
	localparam int LBA_W = 32;

	// Word index inside one 256-word SD buffer
	localparam int BUFF_ADDR_W = 8;

	// Final block of the image
	// 128 backup RAM blocks then 4 memory card blocks
	localparam logic [7:0] LAST_BLOCK = 8'h83;

	// ====================
	// Storage geometry
	// ====================

	// Data word width on both SD and console sides
	localparam int WORD_W = 16;

	// Backup RAM, 32K words
	localparam int BACKUP_ADDR_W = 15;

	// Memory card, 1K words on the host side
	localparam int CARD_WORD_ADDR_W = 10;

	// Memory card, 2K bytes on the console side
	localparam int CARD_BYTE_ADDR_W = 11;

	// ====================
	// Block address decode
	// ====================

	// Low byte of the SD block address
	// Top bit selects the memory card in both views
	typedef union packed
	{
		// Blocks 0x00 to 0x7F
		struct packed
		{
			logic card;
			logic [6:0] bank;
		} backup;
		// Blocks 0x80 to 0x83
		struct packed
		{
			logic card;
			logic [4:0] pad;
			logic [1:0] cblk;
		} card;
	} block_addr_u;

endpackage

//--- sd_block_counter.sv
`timescale 1ns/1ns

module sd_block_counter
(
	input  logic clk_sys,
	input  logic nBNKB,
	// Restart at block 0
	input  logic clr,
	// Advance to the next block
	input  logic step,
	output logic [neo_save_pkg::LBA_W-1:0] lba,
	// Current block is the final one
	output logic last
);

	import neo_save_pkg::*;

	// ====================
	// Block address
	// ====================

	// Clear wins over step
	// Both land on the next clock edge
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			lba <= '0;
		end
		else if (clr)
		begin
			lba <= '0;
		end
		else if (step)
		begin
			lba <= lba + LBA_W'(1);
		end
	end

	// Only the low byte carries the image position
	// Upper bits stay zero for a valid transfer
	// Image length is known here and nowhere else
	assign last = (lba[7:0] == LAST_BLOCK);

endmodule

//--- save_transfer_fsm.sv
`timescale 1ns/1ns

module save_transfer_fsm
(
	input  logic clk_sys,
	input  logic nBNKB,
	input  logic ioctl_download,
	input  logic memcard_save,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic img_size_nonzero,
	input  logic sd_ack,
	input  logic last,
	output logic clr,
	output logic step,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy
);

	// Input samples and their previous values
	logic dl_r, dl_prev;
	logic save_r, save_prev;
	logic ack_r, ack_prev;
	// Transfer gate and armed load
	logic ena;
	logic load_pend, load_prev;
	// Transfer state, high while moving blocks
	logic xfer;
	// Direction of the running transfer, high for load
	logic dir_load;
	// Edge strobes
	logic dl_rise, dl_fall, load_rise, save_rise, ack_rise, ack_fall;
	logic start;

	// ====================
	// Edge detection
	// ====================

	// Inputs sampled once, then compared with last cycle
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			dl_r <= 1'b0;
			dl_prev <= 1'b0;
			save_r <= 1'b0;
			save_prev <= 1'b0;
			ack_r <= 1'b0;
			ack_prev <= 1'b0;
			load_prev <= 1'b0;
		end
		else
		begin
			dl_r <= ioctl_download;
			dl_prev <= dl_r;
			save_r <= memcard_save;
			save_prev <= save_r;
			ack_r <= sd_ack;
			ack_prev <= ack_r;
			load_prev <= load_pend;
		end
	end

	assign dl_rise = dl_r & ~dl_prev;
	assign dl_fall = ~dl_r & dl_prev;
	assign load_rise = load_pend & ~load_prev;
	assign save_rise = save_r & ~save_prev;
	assign ack_rise = ack_r & ~ack_prev;
	assign ack_fall = ~ack_r & ack_prev;

	// ====================
	// Gate and load arming
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			ena <= 1'b0;
			load_pend <= 1'b0;
		end
		else
		begin
			// Closed on download start
			if (dl_rise)
				ena <= 1'b0;
			// Open only with a usable writable image and no download
			if (~dl_r & img_mounted & img_size_nonzero & ~img_readonly)
				ena <= 1'b1;
			// Armed by download end
			// Dropped once its edge was seen, taken or refused
			if (dl_fall)
				load_pend <= 1'b1;
			else if (load_prev)
				load_pend <= 1'b0;
		end
	end

	// Load edge has priority over a save edge in the same cycle
	assign start = ~xfer & ena & (load_rise | save_rise);

	// ====================
	// Transfer FSM
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			xfer <= 1'b0;
			dir_load <= 1'b0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end
		else if (!xfer)
		begin
			// Idle, first request goes out with the counter cleared
			if (start)
			begin
				xfer <= 1'b1;
				dir_load <= load_rise;
				sd_rd <= load_rise;
				sd_wr <= ~load_rise;
			end
		end
		else
		begin
			// Host took the request
			if (ack_rise)
			begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			// Host done with the block
			if (ack_fall)
			begin
				if (last)
				begin
					xfer <= 1'b0;
				end
				else
				begin
					sd_rd <= dir_load;
					sd_wr <= ~dir_load;
				end
			end
		end
	end

	// Counter moves on the same edge as the new request
	assign clr = start;
	assign step = xfer & ack_fall & ~last;
	assign busy = xfer;

endmodule

//--- backup_ram_store.sv
`timescale 1ns/1ns

module backup_ram_store
(
	input  logic clk_sys,
	input  logic nBNKB,
	// High in MVS mode
	input  logic system_mode,
	// Console port
	input  logic [neo_save_pkg::BACKUP_ADDR_W-1:0] cpu_addr,
	input  logic [neo_save_pkg::WORD_W-1:0] cpu_din,
	input  logic cpu_we_l,
	input  logic cpu_we_u,
	output logic [neo_save_pkg::WORD_W-1:0] cpu_dout,
	// Host SD buffer port
	input  neo_save_pkg::block_addr_u blk,
	input  logic [neo_save_pkg::BUFF_ADDR_W-1:0] sd_buff_addr,
	input  logic [neo_save_pkg::WORD_W-1:0] sd_buff_dout,
	input  logic host_wr,
	output logic [neo_save_pkg::WORD_W-1:0] host_dout
);

	import neo_save_pkg::*;

	// Byte lanes, so the console can write halves
	logic [7:0] ram_l [0:(1 << BACKUP_ADDR_W)-1];
	logic [7:0] ram_u [0:(1 << BACKUP_ADDR_W)-1];

	logic [BACKUP_ADDR_W-1:0] host_addr;
	logic host_we;
	logic we_l, we_u;
	logic [WORD_W-1:0] cpu_q;
	// Mode seen with the read address
	logic mode_r;

	// ====================
	// Console side
	// ====================

	// No backup RAM outside MVS mode
	assign we_l = system_mode & cpu_we_l;
	assign we_u = system_mode & cpu_we_u;

	always_ff @(posedge clk_sys)
	begin
		if (we_l)
			ram_l[cpu_addr] <= cpu_din[7:0];
		if (we_u)
			ram_u[cpu_addr] <= cpu_din[15:8];
		cpu_q <= {ram_u[cpu_addr], ram_l[cpu_addr]};
	end

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			mode_r <= 1'b0;
		else
			mode_r <= system_mode;
	end

	// Reads as zero in console mode
	assign cpu_dout = mode_r ? cpu_q : '0;

	// ====================
	// Host side
	// ====================

	// 128 blocks of 256 words
	assign host_addr = {blk.backup.bank, sd_buff_addr};
	// Card blocks are not ours
	assign host_we = host_wr & ~blk.backup.card;

	always_ff @(posedge clk_sys)
	begin
		if (host_we)
		begin
			ram_l[host_addr] <= sd_buff_dout[7:0];
			ram_u[host_addr] <= sd_buff_dout[15:8];
		end
		host_dout <= {ram_u[host_addr], ram_l[host_addr]};
	end

endmodule

//--- memcard_store.sv
`timescale 1ns/1ns

module memcard_store
(
	input  logic clk_sys,
	// Console port, byte wide
	input  logic [neo_save_pkg::CARD_BYTE_ADDR_W-1:0] card_addr,
	input  logic [7:0] card_din,
	input  logic card_we,
	output logic [7:0] card_dout,
	// Host SD buffer port, word wide
	input  neo_save_pkg::block_addr_u blk,
	input  logic [neo_save_pkg::BUFF_ADDR_W-1:0] sd_buff_addr,
	input  logic [neo_save_pkg::WORD_W-1:0] sd_buff_dout,
	input  logic host_wr,
	output logic [neo_save_pkg::WORD_W-1:0] host_dout
);

	import neo_save_pkg::*;

	// Two byte halves of the same word array
	// Odd console bytes sit in the low half
	logic [7:0] card_lo [0:(1 << CARD_WORD_ADDR_W)-1];
	logic [7:0] card_hi [0:(1 << CARD_WORD_ADDR_W)-1];

	logic [CARD_WORD_ADDR_W-1:0] cpu_word;
	logic [CARD_WORD_ADDR_W-1:0] host_addr;
	logic host_we;
	logic [7:0] lo_q, hi_q;
	// Half select delayed with the read
	logic sel_r;

	// ====================
	// Console side
	// ====================

	// Byte address bit 0 picks the half
	assign cpu_word = card_addr[CARD_BYTE_ADDR_W-1:1];

	always_ff @(posedge clk_sys)
	begin
		if (card_we & card_addr[0])
			card_lo[cpu_word] <= card_din;
		if (card_we & ~card_addr[0])
			card_hi[cpu_word] <= card_din;
		lo_q <= card_lo[cpu_word];
		hi_q <= card_hi[cpu_word];
		sel_r <= card_addr[0];
	end

	assign card_dout = sel_r ? lo_q : hi_q;

	// ====================
	// Host side
	// ====================

	// 4 blocks of 256 words
	assign host_addr = {blk.card.cblk, sd_buff_addr};
	// Only blocks 0x80 and up
	assign host_we = host_wr & blk.card.card;

	always_ff @(posedge clk_sys)
	begin
		if (host_we)
		begin
			card_lo[host_addr] <= sd_buff_dout[7:0];
			card_hi[host_addr] <= sd_buff_dout[15:8];
		end
		host_dout <= {card_hi[host_addr], card_lo[host_addr]};
	end

endmodule

//--- save_image_top.sv
`timescale 1ns/1ns

module save_image_top
(
	input  logic clk_sys,
	input  logic nBNKB,
	// Control levels
	input  logic ioctl_download,
	input  logic memcard_save,
	input  logic system_mode,
	// Image state from the host
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic img_size_nonzero,
	// Host SD block buffer
	input  logic sd_ack,
	input  logic [neo_save_pkg::BUFF_ADDR_W-1:0] sd_buff_addr,
	input  logic [neo_save_pkg::WORD_W-1:0] sd_buff_dout,
	input  logic sd_buff_wr,
	output logic [neo_save_pkg::LBA_W-1:0] sd_lba,
	output logic sd_rd,
	output logic sd_wr,
	output logic [neo_save_pkg::WORD_W-1:0] sd_buff_din,
	// Console backup RAM
	input  logic [neo_save_pkg::BACKUP_ADDR_W-1:0] cpu_addr,
	input  logic [neo_save_pkg::WORD_W-1:0] cpu_din,
	input  logic cpu_we_l,
	input  logic cpu_we_u,
	output logic [neo_save_pkg::WORD_W-1:0] cpu_dout,
	// Console memory card
	input  logic [neo_save_pkg::CARD_BYTE_ADDR_W-1:0] card_addr,
	input  logic [7:0] card_din,
	input  logic card_we,
	output logic [7:0] card_dout,
	// Transfer running
	output logic busy
);

	import neo_save_pkg::*;

	logic clr, step, last;
	logic host_wr;
	block_addr_u blk;
	logic [WORD_W-1:0] backup_host_dout;
	logic [WORD_W-1:0] card_host_dout;
	// Card flag aligned with the registered read data
	logic card_sel_r;

	// ====================
	// Transfer control
	// ====================

	sd_block_counter i_counter
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.clr(clr),
		.step(step),
		.lba(sd_lba),
		.last(last)
	);

	save_transfer_fsm i_fsm
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.ioctl_download(ioctl_download),
		.memcard_save(memcard_save),
		.img_mounted(img_mounted),
		.img_readonly(img_readonly),
		.img_size_nonzero(img_size_nonzero),
		.sd_ack(sd_ack),
		.last(last),
		.clr(clr),
		.step(step),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.busy(busy)
	);

	// ====================
	// Storage
	// ====================

	assign blk = sd_lba[7:0];
	// Buffer writes only count while the host acks
	assign host_wr = sd_buff_wr & sd_ack;

	backup_ram_store i_backup
	(
		.clk_sys(clk_sys),
		.nBNKB(nBNKB),
		.system_mode(system_mode),
		.cpu_addr(cpu_addr),
		.cpu_din(cpu_din),
		.cpu_we_l(cpu_we_l),
		.cpu_we_u(cpu_we_u),
		.cpu_dout(cpu_dout),
		.blk(blk),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.host_wr(host_wr),
		.host_dout(backup_host_dout)
	);

	memcard_store i_card
	(
		.clk_sys(clk_sys),
		.card_addr(card_addr),
		.card_din(card_din),
		.card_we(card_we),
		.card_dout(card_dout),
		.blk(blk),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.host_wr(host_wr),
		.host_dout(card_host_dout)
	);

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			card_sel_r <= 1'b0;
		else
			card_sel_r <= blk.card.card;
	end

	// Save data back to the host
	assign sd_buff_din = card_sel_r ? card_host_dout : backup_host_dout;

endmodule

//--- save_image_props.sv
`timescale 1ns/1ns

module save_image_props
(
	input logic clk_sys,
	input logic nBNKB,
	input logic sd_ack,
	input logic sd_rd,
	input logic sd_wr,
	input logic busy,
	input logic clr,
	input logic step,
	input logic last
);

	// One direction at a time
	a_one_dir: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		!(sd_rd && sd_wr))
	else $error("sd_rd and sd_wr high together");

	// Requests only inside a transfer
	a_req_busy: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		(sd_rd || sd_wr) |-> busy)
	else $error("SD request outside a transfer");

	// Start raises busy and the first request together
	a_start: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		clr |=> (busy && (sd_rd || sd_wr)))
	else $error("Transfer start without a request");

	// Block step follows the host dropping ack by one cycle
	a_step: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		step |-> ($past(sd_ack, 2) && !$past(sd_ack)))
	else $error("Block step without an ack fall");

	// Transfer ends only on the final block
	a_end: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		$fell(busy) |-> $past(last))
	else $error("Transfer ended before the last block");

	// Request dropped two cycles after ack rise
	a_ack_drop: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		($past(sd_ack, 2) && !$past(sd_ack, 3)) |-> !(sd_rd || sd_wr))
	else $error("SD request still high after ack");

endmodule

bind save_transfer_fsm save_image_props i_props
(
	.clk_sys(clk_sys),
	.nBNKB(nBNKB),
	.sd_ack(sd_ack),
	.sd_rd(sd_rd),
	.sd_wr(sd_wr),
	.busy(busy),
	.clr(clr),
	.step(step),
	.last(last)
);

//--- tb_save_image.sv
`timescale 1ns/1ns

module tb_save_image;

	import neo_save_pkg::*;

	localparam int HALF_PERIOD = 2;
	localparam int REQ_TIMEOUT = 200;
	localparam int IDLE_WINDOW = 40;
	localparam int PAT_DEPTH = 256;
	localparam int NUM_BLOCKS = 132;
	localparam logic [31:0] LFSR_SEED = 32'd90683;

	logic clk_sys, nBNKB;
	logic ioctl_download, memcard_save, system_mode;
	logic img_mounted, img_readonly, img_size_nonzero;
	logic sd_ack, sd_buff_wr, sd_rd, sd_wr, busy;
	logic [BUFF_ADDR_W-1:0] sd_buff_addr;
	logic [WORD_W-1:0] sd_buff_dout, sd_buff_din;
	logic [LBA_W-1:0] sd_lba;
	logic [BACKUP_ADDR_W-1:0] cpu_addr;
	logic [WORD_W-1:0] cpu_din, cpu_dout;
	logic cpu_we_l, cpu_we_u, card_we;
	logic [CARD_BYTE_ADDR_W-1:0] card_addr;
	logic [7:0] card_din, card_dout;

	// Host copy of both images
	logic [WORD_W-1:0] backup_mirror [0:(1 << BACKUP_ADDR_W)-1];
	logic [WORD_W-1:0] card_mirror [0:(1 << CARD_WORD_ADDR_W)-1];
	// Four words per command line
	logic [15:0] pat [0:PAT_DEPTH-1];
	logic [31:0] lfsr_state;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	logic timed_out = 1'b0;
	// Request edges seen on the SD side
	int rd_reqs = 0;
	int wr_reqs = 0;
	logic rd_prev = 1'b0;
	logic wr_prev = 1'b0;

	save_image_top i_dut (.*);

	always #HALF_PERIOD clk_sys = ~clk_sys;

	always @(posedge clk_sys)
	begin
		rd_prev <= sd_rd;
		wr_prev <= sd_wr;
		if (sd_rd & ~rd_prev)
			rd_reqs <= rd_reqs + 1;
		if (sd_wr & ~wr_prev)
			wr_reqs <= wr_reqs + 1;
	end

	// ====================
	// Random words
	// ====================

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic next_random_word(output logic [15:0] w);
		w = '0;
		for (int k = 0; k < 16; k++)
		begin
			w = {w[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// ====================
	// Host SD model
	// ====================

	// Blocks 0x80 and up hold the card
	function automatic logic [15:0] mirror_word(input logic [7:0] b, input logic [7:0] idx);
		if (b[7])
			return card_mirror[{b[1:0], idx}];
		return backup_mirror[{b[6:0], idx}];
	endfunction

	task automatic wait_request(input logic load, input int blk);
		int n;
		n = 0;
		while (!(sd_rd | sd_wr) && n < REQ_TIMEOUT)
		begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (!(sd_rd | sd_wr))
		begin
			$display("Timeout: no SD request arrived for block %0d", blk);
			timeouts++;
			timed_out = 1'b1;
			return;
		end
		checks++;
		assert (sd_rd == load && sd_wr == !load && sd_lba == LBA_W'(blk))
		else
		begin
			errors++;
			$display("Error %0t: request rd=%b wr=%b lba=%0d, expected block %0d",
				$time, sd_rd, sd_wr, sd_lba, blk);
		end
	endtask

	// Ack held for all 256 words of the block
	task automatic serve_block(input logic load, input int blk);
		logic [15:0] w;
		logic [7:0] b, idx;
		b = 8'(blk);
		sd_ack = 1'b1;
		for (int i = 0; i < 256; i++)
		begin
			idx = 8'(i);
			sd_buff_addr = idx;
			if (load)
			begin
				next_random_word(w);
				sd_buff_dout = w;
				sd_buff_wr = 1'b1;
				if (b[7])
					card_mirror[{b[1:0], idx}] = w;
				else
					backup_mirror[{b[6:0], idx}] = w;
			end
			@(posedge clk_sys);
			#1;
			// Save data is one cycle behind the address
			if (!load)
			begin
				checks++;
				assert (sd_buff_din === mirror_word(b, idx))
				else
				begin
					errors++;
					$display("Error %0t: save block %0d word %0d gave %h, expected %h",
						$time, blk, i, sd_buff_din, mirror_word(b, idx));
				end
			end
		end
		sd_buff_wr = 1'b0;
		sd_ack = 1'b0;
	endtask

	task automatic run_transfer(input logic load);
		int rd0, wr0, n;
		rd0 = rd_reqs;
		wr0 = wr_reqs;
		for (int blk = 0; blk < NUM_BLOCKS; blk++)
		begin
			wait_request(load, blk);
			if (timed_out)
				return;
			serve_block(load, blk);
		end
		n = 0;
		while (busy && n < REQ_TIMEOUT)
		begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (busy)
		begin
			$display("Timeout: busy stayed high after the last block");
			timeouts++;
			timed_out = 1'b1;
			return;
		end
		checks++;
		assert (rd_reqs - rd0 == (load ? NUM_BLOCKS : 0) &&
			wr_reqs - wr0 == (load ? 0 : NUM_BLOCKS))
		else
		begin
			errors++;
			$display("Error %0t: %0d reads and %0d writes requested",
				$time, rd_reqs - rd0, wr_reqs - wr0);
		end
	endtask

	// ====================
	// Console side
	// ====================

	task automatic backup_access(input logic wr, input logic [15:0] a, input logic [15:0] d,
		input logic [15:0] e);
		logic [15:0] exp_val;
		cpu_addr = a[BACKUP_ADDR_W-1:0];
		cpu_din = d;
		cpu_we_l = wr & e[0];
		cpu_we_u = wr & e[1];
		@(posedge clk_sys);
		#1;
		cpu_we_l = 1'b0;
		cpu_we_u = 1'b0;
		// Ignored outside MVS mode
		if (wr && system_mode)
		begin
			if (e[0])
				backup_mirror[cpu_addr][7:0] = d[7:0];
			if (e[1])
				backup_mirror[cpu_addr][15:8] = d[15:8];
		end
		if (!wr)
		begin
			exp_val = d[0] ? (system_mode ? backup_mirror[cpu_addr] : 16'h0) : e;
			checks++;
			assert (cpu_dout === exp_val)
			else
			begin
				errors++;
				$display("Error %0t: backup read at %h gave %h, expected %h",
					$time, cpu_addr, cpu_dout, exp_val);
			end
		end
	endtask

	task automatic card_access(input logic wr, input logic [15:0] a, input logic [15:0] d,
		input logic [15:0] e);
		logic [15:0] word;
		logic [7:0] exp_val;
		card_addr = a[CARD_BYTE_ADDR_W-1:0];
		card_din = d[7:0];
		card_we = wr;
		@(posedge clk_sys);
		#1;
		card_we = 1'b0;
		word = card_mirror[card_addr[10:1]];
		// Odd byte is the low half
		if (wr && card_addr[0])
			card_mirror[card_addr[10:1]][7:0] = d[7:0];
		if (wr && !card_addr[0])
			card_mirror[card_addr[10:1]][15:8] = d[7:0];
		if (!wr)
		begin
			exp_val = d[0] ? (card_addr[0] ? word[7:0] : word[15:8]) : e[7:0];
			checks++;
			assert (card_dout === exp_val)
			else
			begin
				errors++;
				$display("Error %0t: card read at %h gave %h, expected %h",
					$time, card_addr, card_dout, exp_val);
			end
		end
	endtask

	// ====================
	// Control
	// ====================

	// 0 download end, 1 save edge, 2 save edge during a download
	task automatic check_idle(input logic [15:0] how);
		if (how != 16'h1)
			ioctl_download = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		if (how == 16'h0)
			ioctl_download = 1'b0;
		if (how != 16'h0)
			memcard_save = 1'b1;
		repeat (IDLE_WINDOW)
		begin
			@(posedge clk_sys);
			#1;
			checks++;
			assert (!busy && !sd_rd && !sd_wr)
			else
			begin
				errors++;
				$display("Error %0t: transfer started in idle case %0d", $time, how);
			end
		end
		memcard_save = 1'b0;
	endtask

	task automatic run_command(input logic [15:0] cmd, input logic [15:0] a,
		input logic [15:0] d, input logic [15:0] e);
		case (cmd)
			16'h1:
			begin
				ioctl_download = 1'b1;
				repeat (4) @(posedge clk_sys);
				#1;
				ioctl_download = 1'b0;
				run_transfer(1'b1);
			end
			16'h2: backup_access(1'b1, a, d, e);
			16'h3: backup_access(1'b0, a, d, e);
			16'h4: card_access(1'b1, a, d, e);
			16'h5: card_access(1'b0, a, d, e);
			16'h6:
			begin
				memcard_save = 1'b1;
				run_transfer(1'b0);
				memcard_save = 1'b0;
			end
			16'h7: system_mode = d[0];
			16'h8:
			begin
				img_mounted = d[0];
				img_readonly = d[1];
				img_size_nonzero = d[2];
				repeat (2) @(posedge clk_sys);
				#1;
			end
			16'h9: check_idle(d);
			default:
			begin
				errors++;
				$display("Unknown command %h in the pattern file", cmd);
			end
		endcase
	endtask

	initial
	begin
		int p;
		clk_sys = 1'b0;
		nBNKB = 1'b0;
		ioctl_download = 1'b0;
		memcard_save = 1'b0;
		system_mode = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b0;
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		cpu_addr = '0;
		cpu_din = '0;
		cpu_we_l = 1'b0;
		cpu_we_u = 1'b0;
		card_addr = '0;
		card_din = '0;
		card_we = 1'b0;
		lfsr_state = LFSR_SEED;
		$readmemh("save_patterns.txt", pat);
		repeat (4) @(posedge clk_sys);
		#1;
		nBNKB = 1'b1;
		@(posedge clk_sys);
		#1;
		p = 0;
		while (!timed_out && p + 3 < PAT_DEPTH && pat[p] != 16'h0)
		begin
			run_command(pat[p], pat[p + 1], pat[p + 2], pat[p + 3]);
			p += 4;
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- save_patterns.txt
// cmd addr data exp, hex, one command per line
// cmd 1 load, 2/3 backup wr/rd, 4/5 card wr/rd, 6 save, 7 mode, 8 image flags, 9 idle
// writes: exp = byte lanes; reads: data 1 = compare with mirror, data 0 = with exp
0007 0000 0001 0000
0009 0000 0000 0000
0009 0000 0001 0000
0008 0000 0007 0000
0009 0000 0001 0000
0008 0000 0005 0000
0001 0000 0000 0000
0003 0000 0001 0000
0003 7fff 0001 0000
0003 1234 0001 0000
0005 0000 0001 0000
0005 07ff 0001 0000
0005 0213 0001 0000
0002 1234 beef 0003
0003 1234 0000 beef
0002 0100 a55a 0001
0003 0100 0001 0000
0004 0213 00c3 0000
0005 0213 0000 00c3
0006 0000 0000 0000
0007 0000 0000 0000
0003 1234 0000 0000
0002 2000 1111 0003
0004 0400 005a 0000
0006 0000 0000 0000
0007 0000 0001 0000
0003 2000 0001 0000
0003 1234 0000 beef
0005 0400 0000 005a
0009 0000 0002 0000
0001 0000 0000 0000
0003 0042 0001 0000
0005 0101 0001 0000
0000 0000 0000 0000

//--- src.f
neo_save_pkg.sv
sd_block_counter.sv
save_transfer_fsm.sv
backup_ram_store.sv
memcard_store.sv
save_image_top.sv
save_image_props.sv
tb_save_image.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_save_image -f src.f -o sim_save_image
./obj_dir/sim_save_image | tee sim.log
if grep -qx "Simulation passed" sim.log
then
	exit 0
fi
echo "Run failed, see sim.log"
exit 1
